// ==== src.f ====
source/gantry_pkg.sv
source/step_tick_gen.sv
source/site_coord_lut.sv
source/move_program_builder.sv
source/waypoint_sequencer.sv
source/gantry_motion_top.sv
tests/tb_gantry_motion_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gantry motion testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_gantry_motion_top -o sim_gantry_motion \
    && ./obj_dir/sim_gantry_motion > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/tb_gantry_motion_top.sv ====
// gantry motion top testbench with clock, reset, stimulus, reference model and checks
`timescale 1ns/1ps

module tb_gantry_motion_top;

    import gantry_pkg::*;

    localparam int STEP_PERIOD = 20;
    localparam int NUM_MOVES   = 7;                        // idle run counts as one
    localparam int CYCLE_LIMIT = 40 * STEP_PERIOD * NUM_MOVES;

    logic      sys_clk;
    logic      sys_rst_n;
    logic      move_start;
    move_req_t move_req;
    logic      ready_x;
    logic      ready_y;
    logic      ready_z;
    waypoint_t goal;
    logic      program_done;

    // reference model state
    waypoint_t exp_prog [NUM_STEPS];
    waypoint_t exp_goal;
    move_req_t exp_req;
    int        exp_idx;
    logic      exp_loaded;                                 // program_loaded cycle
    logic      req_seen;
    logic      tick_now;
    int        run_cyc;                                    // edges since reset release

    int        check_cnt;
    int        error_cnt;
    int        timeout_cyc;
    int        busy_axis;
    waypoint_t held_goal;

    gantry_motion_top #(
        .STEP_PERIOD (STEP_PERIOD)
    ) i_gantry_motion_top (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .move_start   (move_start),
        .move_req     (move_req),
        .ready_x      (ready_x),
        .ready_y      (ready_y),
        .ready_z      (ready_z),
        .goal         (goal),
        .program_done (program_done)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;                    // 100 ns period
    end

    function automatic waypoint_t park_point();
        waypoint_t wp;
        wp.magnet = 1'b0;
        wp.x      = PARK_X;
        wp.y      = PARK_Y;
        wp.z      = Z_RAISED;
        return wp;
    endfunction

    function automatic logic site_valid(input site_idx_t site);
        return (site >= 4'd1) && (site <= 4'd9);
    endfunction

    // lowered position of a valid site with the magnet off
    function automatic waypoint_t site_point(input logic in_rack, input site_idx_t site);
        waypoint_t wp;
        int        n;
        n         = int'(site) - 1;
        wp.magnet = 1'b0;
        if (in_rack) begin
            wp.x = STORAGE_XY[n].x;
            wp.y = STORAGE_XY[n].y;
            wp.z = Z_LOWER_STORAGE;
        end else begin
            wp.x = BOARD_COL_X[n / 3];                     // column picks x
            wp.y = BOARD_ROW_Y[n % 3];
            wp.z = Z_LOWER_BOARD;
        end
        return wp;
    endfunction

    function automatic site_idx_t random_site();
        return site_idx_t'(1 + ($urandom % 9));
    endfunction

    // expected eleven-step program for one request
    task automatic build_expected(input move_req_t req);
        logic pick_in_rack;
        pick_in_rack = (req.kind == to_board);
        for (int s = 0; s < 4; s++) begin
            if (site_valid(req.pick_site)) begin
                exp_prog[s]        = site_point(pick_in_rack, req.pick_site);
                exp_prog[s].magnet = (s >= 2);             // grab on the second low step
                if (s == 0 || s == 3) begin
                    exp_prog[s].z = Z_RAISED;
                end
            end else begin
                exp_prog[s] = park_point();
            end
            if (site_valid(req.place_site)) begin
                exp_prog[4 + s]        = site_point(!pick_in_rack, req.place_site);
                exp_prog[4 + s].magnet = (s < 2);          // release on the second low step
                if (s == 0 || s == 3) begin
                    exp_prog[4 + s].z = Z_RAISED;
                end
            end else begin
                exp_prog[4 + s] = park_point();
            end
        end
        for (int p = 8; p < 11; p++) begin
            exp_prog[p] = park_point();
        end
    endtask

    task automatic compare_waypoint(input string name, input waypoint_t got,
                                    input waypoint_t exp);
        check_cnt++;
        assert (got === exp) else begin
            error_cnt++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        assert (got === exp) else begin
            error_cnt++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic start_move(input move_kind_t mk, input site_idx_t pick,
                              input site_idx_t place);
        @(posedge sys_clk);
        move_req.kind       <= mk;
        move_req.pick_site  <= pick;
        move_req.place_site <= place;
        move_start          <= 1'b1;
        @(posedge sys_clk);
        move_start <= 1'b0;
        @(posedge sys_clk);                                // sequencer restarts here
        @(negedge sys_clk);
        compare_bit("program_done", program_done, 1'b0);
    endtask

    task automatic wait_program_done();
        @(negedge sys_clk);
        while (!program_done) begin
            @(negedge sys_clk);
        end
    endtask

    // cycle model of the step timing using the inputs from before the edge
    always @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            run_cyc    = 0;
            exp_idx    = 0;
            exp_goal   = RESET_WAYPOINT;
            exp_loaded = 1'b0;
            req_seen   = 1'b0;
            exp_req    = '0;
            for (int i = 0; i < 11; i++) begin
                exp_prog[i] = RESET_WAYPOINT;
            end
        end else begin
            tick_now = (run_cyc != 0) && (run_cyc % STEP_PERIOD == 0);
            run_cyc++;
            if (exp_loaded) begin
                exp_idx = 0;                               // a fresh program beats the tick
            end else if (tick_now && ready_x && ready_y && ready_z && exp_idx < 11) begin
                exp_goal = exp_prog[exp_idx];
                exp_idx++;
            end
            if (move_start) begin
                build_expected(move_req);
                exp_req  = move_req;
                req_seen = 1'b1;
            end
            exp_loaded = move_start;
        end
    end

    always @(negedge sys_clk) begin
        if (sys_rst_n) begin
            compare_waypoint("goal", goal, exp_goal);
            compare_bit("program_done", program_done, exp_idx == 11);
            // an empty phase parks with the magnet off
            if (req_seen && exp_idx >= 1 && exp_idx <= 4
                    && !site_valid(exp_req.pick_site)) begin
                compare_waypoint("goal", goal, park_point());
            end
            if (req_seen && exp_idx >= 5 && exp_idx <= 8
                    && !site_valid(exp_req.place_site)) begin
                compare_waypoint("goal", goal, park_point());
            end
        end
    end

    initial begin
        timeout_cyc = 0;
        while (timeout_cyc < CYCLE_LIMIT) begin
            @(posedge sys_clk);
            timeout_cyc++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("checks %0d, errors %0d", check_cnt, error_cnt);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(95));
        check_cnt  = 0;
        error_cnt  = 0;
        sys_rst_n  = 1'b0;
        move_start = 1'b0;
        move_req   = '0;
        ready_x    = 1'b1;
        ready_y    = 1'b1;
        ready_z    = 1'b1;
        repeat (8) @(posedge sys_clk);
        sys_rst_n <= 1'b1;

        // idle program is eleven reset waypoints
        @(negedge sys_clk);
        compare_waypoint("goal", goal, RESET_WAYPOINT);
        compare_bit("program_done", program_done, 1'b0);
        wait_program_done();
        compare_waypoint("goal", goal, RESET_WAYPOINT);

        start_move(to_board, random_site(), random_site());
        wait_program_done();
        start_move(to_storage, random_site(), random_site());
        wait_program_done();

        // one axis busy across several ticks
        start_move(to_board, random_site(), random_site());
        repeat (3 * STEP_PERIOD) @(posedge sys_clk);
        busy_axis = $urandom % 3;
        case (busy_axis)
            0:       ready_x <= 1'b0;
            1:       ready_y <= 1'b0;
            default: ready_z <= 1'b0;
        endcase
        @(negedge sys_clk);
        held_goal = goal;
        repeat (4 * STEP_PERIOD) begin
            @(negedge sys_clk);
            compare_waypoint("goal", goal, held_goal);
        end
        @(posedge sys_clk);
        ready_x <= 1'b1;
        ready_y <= 1'b1;
        ready_z <= 1'b1;
        wait_program_done();

        start_move(to_storage, 4'd0, random_site());
        wait_program_done();
        start_move(to_board, random_site(), 4'd0);
        wait_program_done();

        // extra ticks after done leave the gantry parked
        repeat (3 * STEP_PERIOD) @(negedge sys_clk);
        compare_waypoint("goal", goal, park_point());
        compare_bit("program_done", program_done, 1'b1);
        start_move(to_storage, random_site(), random_site());
        wait_program_done();

        $display("checks %0d, errors %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== source/gantry_motion_top.sv ====
// gantry motion generator top: step divider, program builder, sequencer
`timescale 1ns/1ps

module gantry_motion_top #(
    parameter int STEP_PERIOD = 10_000_000
) (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  move_start,
    input  gantry_pkg::move_req_t move_req,
    input  logic                  ready_x,
    input  logic                  ready_y,
    input  logic                  ready_z,
    output gantry_pkg::waypoint_t goal,
    output logic                  program_done
);

    import gantry_pkg::*;

    logic      step_tick;
    logic      program_loaded;
    waypoint_t program_table [NUM_STEPS];

    step_tick_gen #(
        .STEP_PERIOD (STEP_PERIOD)
    ) i_step_tick_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .step_tick (step_tick)
    );

    move_program_builder i_move_program_builder (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .move_start     (move_start),
        .move_req       (move_req),
        .program_table  (program_table),
        .program_loaded (program_loaded)
    );

    waypoint_sequencer i_waypoint_sequencer (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .step_tick      (step_tick),
        .program_loaded (program_loaded),
        .program_table  (program_table),
        .ready_x        (ready_x),
        .ready_y        (ready_y),
        .ready_z        (ready_z),
        .goal           (goal),
        .program_done   (program_done)
    );

endmodule

// ==== source/waypoint_sequencer.sv ====
// ready-gated program stepper driving the gantry goal and done level
`timescale 1ns/1ps

module waypoint_sequencer (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  step_tick,
    input  logic                  program_loaded,
    input  gantry_pkg::waypoint_t program_table [gantry_pkg::NUM_STEPS],
    input  logic                  ready_x,
    input  logic                  ready_y,
    input  logic                  ready_z,
    output gantry_pkg::waypoint_t goal,
    output logic                  program_done
);

    import gantry_pkg::*;

    step_idx_t step_idx;
    logic      all_ready;
    logic      step_go;

    assign all_ready = ready_x & ready_y & ready_z;

    // a tick with any axis busy is simply dropped
    assign step_go = step_tick && all_ready && (step_idx != NUM_STEPS);

    assign program_done = (step_idx == NUM_STEPS);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step_idx <= '0;
            goal     <= RESET_WAYPOINT;
        end else if (program_loaded) begin
            step_idx <= '0;                     // new program beats a tick
        end else if (step_go) begin
            goal     <= program_table[step_idx];
            step_idx <= step_idx + 1'b1;
        end
    end

endmodule

// ==== source/move_program_builder.sv ====
// move request latch building the eleven-step pick, place and park program
`timescale 1ns/1ps

module move_program_builder (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  move_start,
    input  gantry_pkg::move_req_t move_req,
    output gantry_pkg::waypoint_t program_table [gantry_pkg::NUM_STEPS],
    output logic                  program_loaded
);

    import gantry_pkg::*;

    waypoint_t pick_pos;
    waypoint_t place_pos;
    logic      pick_ok;
    logic      place_ok;

    // one step of a four-step phase, sub 0..3 = above, low, low, above
    function automatic waypoint_t phase_step(
        input waypoint_t site_pos,
        input logic      site_ok,
        input logic      picking,
        input logic [1:0] sub
    );
        waypoint_t wp;
        logic      lowered;
        lowered = (sub == 2'd1) || (sub == 2'd2);
        if (!site_ok) begin
            wp = PARK_WAYPOINT;                         // empty phase parks
        end else begin
            wp        = site_pos;
            wp.magnet = picking ? sub[1] : ~sub[1];     // grab late, drop late
            if (!lowered) begin
                wp.z = Z_RAISED;
            end
        end
        return wp;
    endfunction

    // pick side comes from the rack when moving onto the board
    site_coord_lut i_pick_lut (
        .storage_site (move_req.kind == to_board),
        .site         (move_req.pick_site),
        .pos          (pick_pos)
    );

    site_coord_lut i_place_lut (
        .storage_site (move_req.kind == to_storage),
        .site         (move_req.place_site),
        .pos          (place_pos)
    );

    assign pick_ok  = (move_req.pick_site >= 4'd1) && (move_req.pick_site <= 4'd9);
    assign place_ok = (move_req.place_site >= 4'd1) && (move_req.place_site <= 4'd9);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < NUM_STEPS; i++) begin
                program_table[i] <= RESET_WAYPOINT;
            end
            program_loaded <= 1'b0;
        end else begin
            program_loaded <= move_start;               // one cycle after the write
            if (move_start) begin
                for (int s = 0; s < 4; s++) begin
                    program_table[PICK_BASE + s]  <=
                        phase_step(pick_pos, pick_ok, 1'b1, 2'(s));
                    program_table[PLACE_BASE + s] <=
                        phase_step(place_pos, place_ok, 1'b0, 2'(s));
                end
                for (int p = PARK_BASE; p < NUM_STEPS; p++) begin
                    program_table[p] <= PARK_WAYPOINT;  // return home
                end
            end
        end
    end

endmodule

// ==== source/site_coord_lut.sv ====
// site to coordinate lookup for the board grid and the storage rack
`timescale 1ns/1ps

module site_coord_lut (
    input  logic                  storage_site,  // 1 = rack, 0 = board
    input  gantry_pkg::site_idx_t site,
    output gantry_pkg::waypoint_t pos
);

    import gantry_pkg::*;

    logic       site_valid;
    site_idx_t  site_off;                    // zero-based site number
    logic [1:0] board_col;
    logic [1:0] board_row;

    assign site_valid = (site >= 4'd1) && (site <= 4'd9);
    assign site_off   = site - 4'd1;

    // 3x3 grid, columns step along x
    assign board_col = 2'(site_off / 4'd3);
    assign board_row = 2'(site_off % 4'd3);

    always_comb begin
        pos = PARK_WAYPOINT;                 // no site -> park, raised
        if (site_valid) begin
            if (storage_site) begin
                pos.x = STORAGE_XY[site_off].x;
                pos.y = STORAGE_XY[site_off].y;
                pos.z = Z_LOWER_STORAGE;
            end else begin
                pos.x = BOARD_COL_X[board_col];
                pos.y = BOARD_ROW_Y[board_row];
                pos.z = Z_LOWER_BOARD;       // board sits slightly higher
            end
        end
    end

endmodule

// ==== source/step_tick_gen.sv ====
// free-running divider giving a one-cycle step strobe
`timescale 1ns/1ps

module step_tick_gen #(
    parameter int STEP_PERIOD = 10_000_000
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    output logic step_tick
);

    localparam int CNT_W = $clog2(STEP_PERIOD + 1);

    logic [CNT_W-1:0] tick_cnt;

    // strobe lands on cycle STEP_PERIOD, then every STEP_PERIOD cycles
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tick_cnt  <= '0;
            step_tick <= 1'b0;
        end else begin
            if (tick_cnt == CNT_W'(STEP_PERIOD - 1)) begin
                tick_cnt  <= '0;                // wrap
                step_tick <= 1'b1;
            end else begin
                tick_cnt  <= tick_cnt + 1'b1;
                step_tick <= 1'b0;
            end
        end
    end

endmodule

// ==== source/gantry_pkg.sv ====
// gantry motion types, site coordinate tables and program step counts
package gantry_pkg;

    typedef logic [15:0] axis_pos_t;        // pulse target, one axis

    typedef struct packed {
        logic      magnet;                  // gripper magnet on
        axis_pos_t x;
        axis_pos_t y;
        axis_pos_t z;
    } waypoint_t;                           // 49 bits, one gantry goal

    typedef logic [3:0] site_idx_t;         // 0 = no site, 1..9 valid

    typedef enum logic {
        to_board   = 1'b0,                  // storage -> board
        to_storage = 1'b1                   // board -> storage
    } move_kind_t;

    typedef struct packed {
        move_kind_t kind;
        site_idx_t  pick_site;
        site_idx_t  place_site;
    } move_req_t;                           // 9 bits

    typedef logic [3:0] step_idx_t;

    typedef struct packed {
        axis_pos_t x;
        axis_pos_t y;
    } site_xy_t;

    // program layout
    localparam step_idx_t NUM_STEPS  = 4'd11;
    localparam step_idx_t PICK_BASE  = 4'd0;
    localparam step_idx_t PLACE_BASE = 4'd4;
    localparam step_idx_t PARK_BASE  = 4'd8;

    localparam waypoint_t RESET_WAYPOINT = '{
        magnet: 1'b0,
        x:      16'h8000,
        y:      16'h8000,
        z:      16'h8000
    };

    // heights
    localparam axis_pos_t Z_RAISED        = 16'h8800;  // travel height
    localparam axis_pos_t Z_LOWER_STORAGE = 16'h6D80;
    localparam axis_pos_t Z_LOWER_BOARD   = 16'h6E80;

    localparam axis_pos_t PARK_X = 16'hB900;
    localparam axis_pos_t PARK_Y = 16'h2250;

    localparam waypoint_t PARK_WAYPOINT = '{
        magnet: 1'b0,
        x:      PARK_X,
        y:      PARK_Y,
        z:      Z_RAISED
    };

    // board grid, site n -> column (n-1)/3, row (n-1)%3
    localparam axis_pos_t BOARD_COL_X [3] = '{16'hB500, 16'h9000, 16'h7500};
    localparam axis_pos_t BOARD_ROW_Y [3] = '{16'h6C00, 16'h8C00, 16'hAC00};

    // storage rack, entry 0 is site 1
    localparam site_xy_t STORAGE_XY [9] = '{
        '{x: 16'hB900, y: 16'h2250},
        '{x: 16'hB900, y: 16'h3D50},
        '{x: 16'h9900, y: 16'h2250},
        '{x: 16'h9900, y: 16'h3A50},
        '{x: 16'h7B00, y: 16'h2250},
        '{x: 16'h7900, y: 16'h3F50},
        '{x: 16'h5A00, y: 16'h2250},
        '{x: 16'h5A00, y: 16'h3F50},
        '{x: 16'h5A00, y: 16'h6000}
    };

endpackage
